//--- Bender.yml
package:
  name: vga_logo

sources:
  - hdl/vga_pkg.sv
  - hdl/vga_timing.sv
  - hdl/logo_rom.sv
  - hdl/pixel_mux.sv
  - hdl/vga_logo_top.sv
  - target: test
    files:
      - testbench/vga_logo_sva.sv
      - testbench/tb_vga_logo.sv

//--- hdl/logo.mem
C00
C01
C02
C03
C04
C05
C06
C07
C10
C11
C12
C13
C14
C15
C16
C17
C20
C21
C22
C23
C24
C25
C26
C27
C30
C31
C32
C33
C34
C35
C36
C37
C40
C41
C42
C43
C44
C45
C46
C47
C50
C51
C52
C53
C54
C55
C56
C57
C60
C61
C62
C63
C64
C65
C66
C67
C70
C71
C72
C73
C74
C75
C76
C77

//--- hdl/logo_rom.sv
`timescale 1ns/10ps
`default_nettype none

module logo_rom
    import vga_pkg::*;
(
    input  logic       clk_vga, // pixel clock
    input  logo_addr_t addr,    // word index from pixel path
    output rgb12_t     data     // image word, one cycle after addr
);

    rgb12_t mem [0:logo_words-1]; // 8x8 image, row major

    // image contents, one hex word per line
    initial
    begin
        $readmemh("hdl/logo.mem", mem);
    end

    // registered read, maps onto block or lut ram
    always_ff @(posedge clk_vga)
    begin
        data <= mem[addr];
    end

endmodule : logo_rom

`default_nettype wire

//--- hdl/pixel_mux.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_mux
    import vga_pkg::*;
(
    input  logic       clk_vga,   // pixel clock
    input  logic       RST_N,     // async, active low
    input  scan_pos_t  pos,       // raster position from timing
    input  rgb12_t     rgb,       // background colour
    output logo_addr_t rom_addr,  // to image rom
    input  rgb12_t     rom_data,  // from image rom, one cycle later
    output logic       vga_hsync, // to connector
    output logic       vga_vsync,
    output logic [3:0] vga_red,
    output logic [3:0] vga_green,
    output logic [3:0] vga_blue
);

    coord_t    dx;       // offset from window left edge
    coord_t    dy;       // offset from window top edge
    coord_t    col;      // source column, dx / scale
    coord_t    row;      // source row, dy / scale
    coord_t    addr_lin; // linear word index
    logic      in_win;   // position inside 64x64 window
    scan_pos_t pos_d1;   // stage 1 position
    rgb12_t    rgb_d1;   // stage 1 background
    logic      win_d1;   // stage 1 window flag
    rgb12_t    pix;      // stage 2 colour

    // window test, offsets wrap negative outside but in_win masks that
    assign dx     = pos.hcnt - logo_x0;
    assign dy     = pos.vcnt - logo_y0;
    assign in_win = (pos.hcnt >= logo_x0) && (pos.hcnt < logo_x0 + logo_side) &&
                    (pos.vcnt >= logo_y0) && (pos.vcnt < logo_y0 + logo_side);

    // each source pixel covers an 8x8 block
    assign col      = coord_t'(dx / logo_scale);
    assign row      = coord_t'(dy / logo_scale);
    assign addr_lin = coord_t'(row * logo_src + col);
    assign rom_addr = in_win ? logo_addr_t'(addr_lin) : '0; // rom samples this edge

    // stage 1, control part
    always_ff @(posedge clk_vga or negedge RST_N)
    begin
        if (!RST_N)
        begin
            pos_d1 <= '0; // syncs low, not active
            win_d1 <= 1'b0;
        end
        else
        begin
            pos_d1 <= pos;
            win_d1 <= in_win;
        end
    end

    // stage 1, background colour alongside
    always_ff @(posedge clk_vga)
    begin
        rgb_d1 <= rgb;
    end

    // stage 2, colour choice lines up with rom output
    always_ff @(posedge clk_vga or negedge RST_N)
    begin
        if (!RST_N)
        begin
            pix       <= '0;
            vga_hsync <= 1'b0;
            vga_vsync <= 1'b0;
        end
        else
        begin
            if (!pos_d1.active)
            begin
                pix <= '0; // black in blanking
            end
            else if (win_d1)
            begin
                pix <= rom_data; // logo word
            end
            else
            begin
                pix <= rgb_d1; // background fill
            end
            vga_hsync <= pos_d1.hsync; // two cycles behind counters
            vga_vsync <= pos_d1.vsync;
        end
    end

    // split 12-bit word onto the pins
    assign vga_red   = pix[11:8];
    assign vga_green = pix[7:4];
    assign vga_blue  = pix[3:0];

endmodule : pixel_mux

`default_nettype wire

//--- hdl/vga_logo_top.sv
`timescale 1ns/10ps
`default_nettype none

module vga_logo_top
    import vga_pkg::*;
(
    input  logic       clk_vga,   // 108 MHz pixel clock from board
    input  logic       RST_N,     // async, active low
    input  rgb12_t     rgb,       // background colour
    output logic       vga_hsync, // positive sync
    output logic       vga_vsync, // positive sync
    output logic [3:0] vga_red,
    output logic [3:0] vga_green,
    output logic [3:0] vga_blue
);

    scan_pos_t  pos;      // timing to pixel path
    logo_addr_t rom_addr; // pixel path to rom
    rgb12_t     rom_data; // rom to pixel path

    // raster counters and sync decode
    vga_timing u_timing (
        .clk_vga (clk_vga),
        .RST_N   (RST_N),
        .pos     (pos)
    );

    // 8x8 logo image
    logo_rom u_rom (
        .clk_vga (clk_vga),
        .addr    (rom_addr),
        .data    (rom_data)
    );

    // window detect and colour select
    pixel_mux u_mux (
        .clk_vga   (clk_vga),
        .RST_N     (RST_N),
        .pos       (pos),
        .rgb       (rgb),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_red   (vga_red),
        .vga_green (vga_green),
        .vga_blue  (vga_blue)
    );

endmodule : vga_logo_top

`default_nettype wire

//--- hdl/vga_pkg.sv
`default_nettype none

package vga_pkg;

    typedef logic [10:0] coord_t;     // column or row count
    typedef logic [11:0] rgb12_t;     // r in [11:8], g in [7:4], b in [3:0]
    typedef logic [5:0]  logo_addr_t; // 8x8 image word index

    // horizontal timing, pixels
    localparam coord_t h_disp  = 11'd1280; // visible columns
    localparam coord_t h_front = 11'd48;   // front porch
    localparam coord_t h_sync  = 11'd112;  // sync pulse
    localparam coord_t h_back  = 11'd248;  // back porch
    localparam coord_t h_total = 11'd1688; // full line

    // vertical timing, lines
    localparam coord_t v_disp  = 11'd1024; // visible rows
    localparam coord_t v_front = 11'd1;    // front porch
    localparam coord_t v_sync  = 11'd3;    // sync pulse
    localparam coord_t v_back  = 11'd38;   // back porch
    localparam coord_t v_total = 11'd1066; // full frame

    // logo window geometry
    localparam coord_t      logo_x0    = 11'd608; // left edge
    localparam coord_t      logo_y0    = 11'd480; // top edge
    localparam int unsigned logo_src   = 8;       // source image side
    localparam int unsigned logo_scale = 8;       // pixel repeat, both axes
    localparam int unsigned logo_words = 64;      // rom depth
    localparam coord_t      logo_side  = coord_t'(logo_src * logo_scale); // 64 on screen

    // raster position seen by the pixel path
    typedef struct packed {
        coord_t hcnt;   // column
        coord_t vcnt;   // row
        logic   hsync;  // positive polarity
        logic   vsync;  // positive polarity
        logic   active; // inside visible area
    } scan_pos_t;

endpackage : vga_pkg

`default_nettype wire

//--- hdl/vga_timing.sv
`timescale 1ns/10ps
`default_nettype none

module vga_timing
    import vga_pkg::*;
(
    input  logic      clk_vga, // pixel clock
    input  logic      RST_N,   // async, active low
    output scan_pos_t pos      // current raster position
);

    coord_t hcnt; // column counter
    coord_t vcnt; // line counter
    logic   h_wrap; // last pixel of line
    logic   v_wrap; // last line of frame

    assign h_wrap = (hcnt == h_total - 1'b1);
    assign v_wrap = (vcnt == v_total - 1'b1);

    // column counter, runs continuously
    always_ff @(posedge clk_vga or negedge RST_N)
    begin
        if (!RST_N)
        begin
            hcnt <= '0;
        end
        else if (h_wrap)
        begin
            hcnt <= '0; // back to column 0
        end
        else
        begin
            hcnt <= hcnt + 1'b1;
        end
    end

    // line counter, steps at the end of every full line
    always_ff @(posedge clk_vga or negedge RST_N)
    begin
        if (!RST_N)
        begin
            vcnt <= '0;
        end
        else if (h_wrap)
        begin
            if (v_wrap)
            begin
                vcnt <= '0; // new frame
            end
            else
            begin
                vcnt <= vcnt + 1'b1;
            end
        end
    end

    // decode straight from the counter registers
    always_comb
    begin
        pos.hcnt   = hcnt;
        pos.vcnt   = vcnt;
        pos.hsync  = (hcnt >= h_disp + h_front) &&
                     (hcnt <  h_disp + h_front + h_sync); // 1328..1439
        pos.vsync  = (vcnt >= v_disp + v_front) &&
                     (vcnt <  v_disp + v_front + v_sync); // 1025..1027
        pos.active = (hcnt < h_disp) && (vcnt < v_disp);
    end

endmodule : vga_timing

`default_nettype wire

//--- src.f
hdl/vga_pkg.sv
hdl/vga_timing.sv
hdl/logo_rom.sv
hdl/pixel_mux.sv
hdl/vga_logo_top.sv
testbench/vga_logo_sva.sv
testbench/tb_vga_logo.sv

//--- testbench/pixel_input.txt
# columns: bg_rgb(hex) h v exp_hsync exp_vsync exp_rgb(hex)
# raster order, a position lower than the one before it starts the next frame
5A3 0 0 0 0 5A3
5A3 640 5 0 0 5A3
0F0 640 10 0 0 0F0
0F0 1279 20 0 0 0F0
0F0 1280 20 0 0 000
0F0 1327 20 0 0 000
0F0 1328 20 1 0 000
0F0 1439 20 1 0 000
0F0 1440 20 0 0 000
0F0 1687 20 0 0 000
123 608 479 0 0 123
123 607 480 0 0 123
123 608 480 0 0 C00
123 616 480 0 0 C01
123 671 480 0 0 C07
123 672 480 0 0 123
123 616 488 0 0 C11
123 623 495 0 0 C11
123 624 496 0 0 C22
123 640 512 0 0 C44
123 608 543 0 0 C70
123 671 543 0 0 C77
123 672 543 0 0 123
123 671 544 0 0 123
9C6 1279 1023 0 0 9C6
9C6 0 1024 0 0 000
9C6 0 1025 0 1 000
9C6 800 1026 0 1 000
9C6 1400 1027 1 1 000
9C6 0 1028 0 0 000
F0F 1687 1065 0 0 000
F0F 0 0 0 0 F0F
F0F 640 512 0 0 C44
F0F 1328 1025 1 1 000

//--- testbench/tb_vga_logo.sv
`timescale 1ns/10ps
`default_nettype none

module tb_vga_logo
    import vga_pkg::*;
();

    localparam int     clk_period   = 20; // ns
    localparam int     reset_cycles = 10;
    localparam longint frame_len    = longint'(h_total) * longint'(v_total); // clocks per frame
    localparam longint wd_cycles    = frame_len * 22 / 10; // vectors span two frames

    logic       clk_vga;
    logic       RST_N;
    rgb12_t     rgb;
    logic       vga_hsync;
    logic       vga_vsync;
    logic [3:0] vga_red;
    logic [3:0] vga_green;
    logic [3:0] vga_blue;
    longint     cycle = 0;      // edges since reset release
    int         errors = 0;
    int         checks = 0;
    string      scan_tag = "reset"; // position shown on mismatch lines

    rgb12_t     vec_bg [$];     // background to drive
    int         vec_h [$];
    int         vec_v [$];
    logic       vec_hs [$];     // expected syncs
    logic       vec_vs [$];
    rgb12_t     vec_rgb [$];    // expected colour
    longint     vec_frame [$];
    longint     vec_tgt [$];    // cycle at which output is checked

    vga_logo_top uut (
        .clk_vga   (clk_vga),
        .RST_N     (RST_N),
        .rgb       (rgb),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_red   (vga_red),
        .vga_green (vga_green),
        .vga_blue  (vga_blue)
    );

    bind vga_logo_top vga_logo_sva u_sva (
        .clk_vga   (clk_vga),
        .RST_N     (RST_N),
        .pos       (pos),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_red   (vga_red),
        .vga_green (vga_green),
        .vga_blue  (vga_blue)
    );

    initial clk_vga = 1'b0;
    always #(clk_period / 2) clk_vga = ~clk_vga; // 50 MHz stand-in for the pixel clock

    always @(posedge clk_vga)
    begin
        if (RST_N)
        begin
            cycle <= cycle + 1;
        end
    end

    task automatic check_value(input string name, input logic [11:0] expected,
                               input logic [11:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("mismatch %s expected %h actual %h at %s", name, expected, actual, scan_tag);
        end
    endtask

    task automatic check_idle();
        check_value("vga_hsync", 12'h0, vga_hsync);
        check_value("vga_vsync", 12'h0, vga_vsync);
        check_value("vga_rgb", 12'h000, {vga_red, vga_green, vga_blue});
    endtask

    task automatic load_vectors();
        int     fd;
        int     n;
        string  line;
        rgb12_t bg;
        rgb12_t col;
        int     h;
        int     v;
        logic   hs;
        logic   vs;
        longint p;
        longint prev;
        longint frame;
        prev  = -1;
        frame = 0;
        fd    = $fopen("testbench/pixel_input.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("could not open testbench/pixel_input.txt");
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#")
            begin
                n = $sscanf(line, "%h %d %d %h %h %h", bg, h, v, hs, vs, col);
                if (n == 6)
                begin
                    p = longint'(v) * h_total + h; // raster index inside a frame
                    if (p <= prev)
                    begin
                        frame++; // raster went back, next frame
                    end
                    prev = p;
                    vec_bg.push_back(bg);
                    vec_h.push_back(h);
                    vec_v.push_back(v);
                    vec_hs.push_back(hs);
                    vec_vs.push_back(vs);
                    vec_rgb.push_back(col);
                    vec_frame.push_back(frame);
                    vec_tgt.push_back(frame * frame_len + p + 2); // two pipeline stages
                end
                else if (n > 0)
                begin
                    errors++;
                    $display("badly formed vector line: %s", line);
                end
            end
        end
        $fclose(fd);
        if (vec_tgt.size() == 0)
        begin
            errors++;
            $display("no vectors were read from the vector file");
        end
    endtask

    task automatic run_vector(input int i);
        while (cycle < vec_tgt[i] - 7)
        begin
            @(negedge clk_vga); // until four positions ahead
        end
        @(posedge clk_vga);
        #1;
        if (vec_bg[i] !== rgb && cycle >= vec_tgt[i] - 1)
        begin
            errors++;
            $display("vector %0d follows too closely to change the background colour", i);
        end
        rgb = vec_bg[i];
        do
        begin
            @(negedge clk_vga); // outputs settled mid cycle
        end
        while (cycle < vec_tgt[i]);
        scan_tag = $sformatf("frame %0d h %0d v %0d", vec_frame[i], vec_h[i], vec_v[i]);
        check_value("vga_hsync", vec_hs[i], vga_hsync);
        check_value("vga_vsync", vec_vs[i], vga_vsync);
        check_value("vga_rgb", vec_rgb[i], {vga_red, vga_green, vga_blue});
    endtask

    initial
    begin
        RST_N = 1'b0;
        rgb   = '0;
        load_vectors();
        if (vec_bg.size() > 0)
        begin
            rgb = vec_bg[0]; // captured on the first edge after release
        end
        repeat (reset_cycles)
        begin
            @(negedge clk_vga);
            check_idle();
        end
        @(posedge clk_vga);
        #1 RST_N = 1'b1;
        @(posedge clk_vga);
        @(negedge clk_vga);
        scan_tag = "first cycle after reset";
        check_idle(); // stage 2 still holds its reset value
        foreach (vec_tgt[i])
        begin
            run_vector(i);
        end
        $display("checks %0d errors %0d assertion failures %0d",
                 checks, errors, uut.u_sva.fail_cnt);
        if (errors == 0 && uut.u_sva.fail_cnt == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // bounded run time
    initial
    begin
        #(wd_cycles * clk_period);
        $display("timeout after %0d cycles before all vectors were checked", wd_cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule : tb_vga_logo

`default_nettype wire

//--- testbench/vga_logo_sva.sv
`timescale 1ns/10ps
`default_nettype none

module vga_logo_sva
    import vga_pkg::*;
(
    input logic       clk_vga,   // pixel clock
    input logic       RST_N,     // async, active low
    input scan_pos_t  pos,       // counter side position
    input logic       vga_hsync,
    input logic       vga_vsync,
    input logic [3:0] vga_red,
    input logic [3:0] vga_green,
    input logic [3:0] vga_blue
);

    localparam int unsigned hs_cycles = int'(h_sync);                 // one pulse in pixels
    localparam int unsigned vs_cycles = int'(v_sync) * int'(h_total); // three whole lines

    int unsigned hs_len;       // high cycles so far
    int unsigned vs_len;
    int          fail_cnt = 0; // failed assertions so far

    // run length of each sync pulse
    always_ff @(posedge clk_vga or negedge RST_N)
    begin
        if (!RST_N)
        begin
            hs_len <= 0;
            vs_len <= 0;
        end
        else
        begin
            hs_len <= vga_hsync ? hs_len + 1 : 0;
            vs_len <= vga_vsync ? vs_len + 1 : 0;
        end
    end

    hsync_width: assert property (@(posedge clk_vga) disable iff (!RST_N)
        $fell(vga_hsync) |-> (hs_len == hs_cycles))
        else
        begin
            fail_cnt++;
            $error("hsync pulse lasted %0d cycles instead of %0d", hs_len, hs_cycles);
        end

    vsync_width: assert property (@(posedge clk_vga) disable iff (!RST_N)
        $fell(vga_vsync) |-> (vs_len == vs_cycles))
        else
        begin
            fail_cnt++;
            $error("vsync pulse lasted %0d cycles instead of %0d", vs_len, vs_cycles);
        end

    // outputs trail the counters by two clocks
    black_in_blanking: assert property (@(posedge clk_vga) disable iff (!RST_N)
        !$past(pos.active, 2) |-> ({vga_red, vga_green, vga_blue} == 12'h000))
        else
        begin
            fail_cnt++;
            $error("colour not black during blanking");
        end

endmodule : vga_logo_sva

`default_nettype wire
